//--- logic/dma_aw_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered FIFO of AW bursts and their decouple flag
// Sits inside the channel coupler in front of release
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dma_params.svh"

module dma_aw_queue import dma_axi_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   push_valid_i,
    output logic   push_ready_o,
    input  addr_t  push_addr_i,
    input  axlen_t push_len_i,
    input  logic   push_decouple_i,
    output logic   pop_valid_o,
    input  logic   pop_ready_i,
    output addr_t  pop_addr_o,
    output axlen_t pop_len_o,
    output logic   pop_decouple_o,
    output logic   empty_o
);

    localparam int PTR_W = $clog2(`DMA_AW_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`DMA_AW_QUEUE_DEPTH + 1);

    // Storage, payload only, no reset
    addr_t  addr_mem [`DMA_AW_QUEUE_DEPTH];
    axlen_t len_mem  [`DMA_AW_QUEUE_DEPTH];
    logic   dec_mem  [`DMA_AW_QUEUE_DEPTH];

    logic [PTR_W-1:0] wptr_q;
    logic [PTR_W-1:0] rptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             push;
    logic             pop;

    assign empty_o      = (cnt_q == '0);
    assign push_ready_o = (cnt_q != CNT_W'(`DMA_AW_QUEUE_DEPTH));
    assign pop_valid_o  = ~empty_o;
    assign push         = push_valid_i & push_ready_o;
    assign pop          = pop_valid_o & pop_ready_i;

    // Head entry straight from storage
    assign pop_addr_o     = addr_mem[rptr_q];
    assign pop_len_o      = len_mem[rptr_q];
    assign pop_decouple_o = dec_mem[rptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_mem[wptr_q] <= push_addr_i;
            len_mem[wptr_q]  <= push_len_i;
            dec_mem[wptr_q]  <= push_decouple_i;
        end
    end

    // Pointers wrap at the depth, count tracks fill level
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wptr_q <= '0;
            rptr_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (push) begin
                wptr_q <= (wptr_q == PTR_W'(`DMA_AW_QUEUE_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= (rptr_q == PTR_W'(`DMA_AW_QUEUE_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
            end
            if (push & ~pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop & ~push) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Pop only requested while an entry is present
    assert property (@(posedge clk_i) disable iff (rst_i)
        pop_ready_i |-> pop_valid_o);

    // Push refused while full is held, so an offered burst is never lost
    assert property (@(posedge clk_i) disable iff (rst_i)
        (push_valid_i & ~push_ready_o) |=>
            (push_valid_i & $stable(push_addr_i) & $stable(push_len_i)
             & $stable(push_decouple_i)));

endmodule

//--- logic/dma_axi_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Field types of the AXI address channels
// Imported by modules that carry AR or AW payload
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dma_params.svh"

package dma_axi_pkg;

    // Byte address on AR and AW
    typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;

    // Burst length, holds beats minus one
    typedef logic [`DMA_LEN_WIDTH-1:0] axlen_t;

endpackage

//--- logic/dma_backend_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address-side DMA backend, splitter to AR and AW
// with AW held back by the R-channel coupler
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dma_params.svh"

module dma_backend_top import dma_axi_pkg::*; (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    input  addr_t                          req_src_addr_i,
    input  addr_t                          req_dst_addr_i,
    input  logic [`DMA_XFER_LEN_WIDTH-1:0] req_len_i,
    input  logic                           req_decouple_i,
    output logic                           ar_valid_o,
    input  logic                           ar_ready_i,
    output addr_t                          ar_addr_o,
    output axlen_t                         ar_len_o,
    // R channel, observed only
    input  logic                           r_valid_i,
    input  logic                           r_ready_i,
    input  logic                           r_last_i,
    output logic                           aw_valid_o,
    input  logic                           aw_ready_i,
    output addr_t                          aw_addr_o,
    output axlen_t                         aw_len_o,
    output logic                           busy_o
);

    // Splitter to coupler
    logic   split_aw_valid;
    logic   split_aw_ready;
    addr_t  split_aw_addr;
    axlen_t split_aw_len;
    logic   split_aw_decouple;

    // AR notice and R first-beat notice
    logic ar_issue;
    logic ar_issue_decouple;
    logic r_first;
    logic r_decouple;

    logic split_busy;
    logic coupler_busy;

    dma_burst_splitter dma_burst_splitter_inst (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .req_valid_i        (req_valid_i),
        .req_ready_o        (req_ready_o),
        .req_src_addr_i     (req_src_addr_i),
        .req_dst_addr_i     (req_dst_addr_i),
        .req_len_i          (req_len_i),
        .req_decouple_i     (req_decouple_i),
        .ar_valid_o         (ar_valid_o),
        .ar_ready_i         (ar_ready_i),
        .ar_addr_o          (ar_addr_o),
        .ar_len_o           (ar_len_o),
        .aw_valid_o         (split_aw_valid),
        .aw_ready_i         (split_aw_ready),
        .aw_addr_o          (split_aw_addr),
        .aw_len_o           (split_aw_len),
        .aw_decouple_o      (split_aw_decouple),
        .ar_issue_o         (ar_issue),
        .ar_issue_decouple_o(ar_issue_decouple),
        .busy_o             (split_busy)
    );

    dma_read_tracker dma_read_tracker_inst (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .ar_issue_i         (ar_issue),
        .ar_issue_decouple_i(ar_issue_decouple),
        .r_valid_i          (r_valid_i),
        .r_ready_i          (r_ready_i),
        .r_last_i           (r_last_i),
        .r_first_o          (r_first),
        .r_decouple_o       (r_decouple)
    );

    dma_channel_coupler dma_channel_coupler_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .aw_valid_i   (split_aw_valid),
        .aw_ready_o   (split_aw_ready),
        .aw_addr_i    (split_aw_addr),
        .aw_len_i     (split_aw_len),
        .aw_decouple_i(split_aw_decouple),
        .r_first_i    (r_first),
        .r_decouple_i (r_decouple),
        .aw_valid_o   (aw_valid_o),
        .aw_ready_i   (aw_ready_i),
        .aw_addr_o    (aw_addr_o),
        .aw_len_o     (aw_len_o),
        .busy_o       (coupler_busy)
    );

    assign busy_o = split_busy | coupler_busy;

endmodule

//--- logic/dma_burst_splitter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cuts a transfer request into AR/AW burst pairs of
// at most the burst limit, one pair at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dma_params.svh"

module dma_burst_splitter
    import dma_axi_pkg::*;
    import dma_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    // Transfer request
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  addr_t     req_src_addr_i,
    input  addr_t     req_dst_addr_i,
    input  xfer_len_t req_len_i,
    input  logic      req_decouple_i,
    // AR channel
    output logic      ar_valid_o,
    input  logic      ar_ready_i,
    output addr_t     ar_addr_o,
    output axlen_t    ar_len_o,
    // AW towards the coupler
    output logic      aw_valid_o,
    input  logic      aw_ready_i,
    output addr_t     aw_addr_o,
    output axlen_t    aw_len_o,
    output logic      aw_decouple_o,
    // AR notice for the read tracker
    output logic      ar_issue_o,
    output logic      ar_issue_decouple_o,
    output logic      busy_o
);

    split_state_e state_q;

    // Transfer context
    addr_t     src_q;
    addr_t     dst_q;
    xfer_len_t remain_q;
    logic      dec_q;

    // Per-burst accepted flags
    logic ar_done_q;
    logic aw_done_q;

    xfer_len_t beats;
    addr_t     step;
    logic      active;
    logic      ar_fire;
    logic      aw_fire;
    logic      ar_ok;
    logic      aw_ok;
    logic      burst_done;
    logic      last_burst;

    // Current burst size and its address step
    assign beats = (remain_q > xfer_len_t'(`DMA_MAX_BURST_BEATS)) ?
                   xfer_len_t'(`DMA_MAX_BURST_BEATS) : remain_q;
    assign step  = addr_t'(beats) * addr_t'(`DMA_BYTES_PER_BEAT);

    assign active      = (state_q != IDLE);
    assign req_ready_o = ~active;
    assign busy_o      = active;

    // Both channels offered together, each drops once accepted
    assign ar_valid_o    = active & ~ar_done_q;
    assign aw_valid_o    = active & ~aw_done_q;
    assign ar_addr_o     = src_q;
    assign aw_addr_o     = dst_q;
    assign ar_len_o      = axlen_t'(beats - xfer_len_t'(1));
    assign aw_len_o      = axlen_t'(beats - xfer_len_t'(1));
    assign aw_decouple_o = dec_q;

    assign ar_fire    = ar_valid_o & ar_ready_i;
    assign aw_fire    = aw_valid_o & aw_ready_i;
    assign ar_ok      = ar_done_q | ar_fire;
    assign aw_ok      = aw_done_q | aw_fire;
    assign burst_done = active & ar_ok & aw_ok;
    assign last_burst = (remain_q == beats);

    assign ar_issue_o          = ar_fire;
    assign ar_issue_decouple_o = dec_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= IDLE;
            ar_done_q <= 1'b0;
            aw_done_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    // Zero-length request is taken and dropped
                    if (req_valid_i && req_len_i != '0) begin
                        state_q <= ISSUE;
                    end
                end
                ISSUE, WAIT_ACCEPT: begin
                    if (burst_done) begin
                        state_q   <= last_burst ? IDLE : ISSUE;
                        ar_done_q <= 1'b0;
                        aw_done_q <= 1'b0;
                    end else begin
                        if (ar_fire | aw_fire) begin
                            state_q <= WAIT_ACCEPT;
                        end
                        ar_done_q <= ar_ok;
                        aw_done_q <= aw_ok;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Context loads on accept and advances per completed burst
    always_ff @(posedge clk_i) begin
        if (req_ready_o & req_valid_i) begin
            src_q    <= req_src_addr_i;
            dst_q    <= req_dst_addr_i;
            remain_q <= req_len_i;
            dec_q    <= req_decouple_i;
        end else if (burst_done) begin
            src_q    <= src_q + step;
            dst_q    <= dst_q + step;
            remain_q <= remain_q - beats;
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        state_q inside {IDLE, ISSUE, WAIT_ACCEPT});

    // Half-accepted pair means exactly one channel is done
    assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == WAIT_ACCEPT) |-> (ar_done_q ^ aw_done_q));

endmodule

//--- logic/dma_channel_coupler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Holds AW bursts back until the matching read data
// starts to arrive, decoupled bursts pass at once
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dma_params.svh"

module dma_channel_coupler
    import dma_axi_pkg::*;
    import dma_ctrl_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    // AW bursts from the splitter
    input  logic   aw_valid_i,
    output logic   aw_ready_o,
    input  addr_t  aw_addr_i,
    input  axlen_t aw_len_i,
    input  logic   aw_decouple_i,
    // First-beat notice from the read tracker
    input  logic   r_first_i,
    input  logic   r_decouple_i,
    // AW channel out
    output logic   aw_valid_o,
    input  logic   aw_ready_i,
    output addr_t  aw_addr_o,
    output axlen_t aw_len_o,
    output logic   busy_o
);

    // Queue head
    logic   q_valid;
    logic   q_ready;
    addr_t  q_addr;
    axlen_t q_len;
    logic   q_decouple;
    logic   q_empty;

    // Release control
    credit_t credit_q;
    logic    credit_in;
    logic    credit_use;
    logic    have_credit;
    logic    reg_free;
    logic    aw_sent;

    // Output valid stage
    logic   aw_valid_q;
    addr_t  aw_addr_q;
    axlen_t aw_len_q;

    dma_aw_queue dma_aw_queue_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .push_valid_i   (aw_valid_i),
        .push_ready_o   (aw_ready_o),
        .push_addr_i    (aw_addr_i),
        .push_len_i     (aw_len_i),
        .push_decouple_i(aw_decouple_i),
        .pop_valid_o    (q_valid),
        .pop_ready_i    (q_ready),
        .pop_addr_o     (q_addr),
        .pop_len_o      (q_len),
        .pop_decouple_o (q_decouple),
        .empty_o        (q_empty)
    );

    // Only first beats of coupled reads earn a credit
    assign credit_in = r_first_i & ~r_decouple_i;

    // Output stage takes a new burst when empty or draining
    assign reg_free = ~aw_valid_q | aw_ready_i;

    // A credit arriving this cycle counts right away
    assign have_credit = (credit_q != '0) | credit_in;

    // Head leaves in order, decoupled ones need no credit
    assign aw_sent    = q_valid & reg_free & (q_decouple | have_credit);
    assign credit_use = aw_sent & ~q_decouple;
    assign q_ready    = aw_sent;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_q <= '0;
        end else begin
            credit_q <= credit_q + credit_t'(credit_in) - credit_t'(credit_use);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            aw_valid_q <= 1'b0;
        end else if (aw_sent) begin
            aw_valid_q <= 1'b1;
        end else if (aw_ready_i) begin
            aw_valid_q <= 1'b0;
        end
    end

    // Payload latched at release
    always_ff @(posedge clk_i) begin
        if (aw_sent) begin
            aw_addr_q <= q_addr;
            aw_len_q  <= q_len;
        end
    end

    assign aw_valid_o = aw_valid_q;
    assign aw_addr_o  = aw_addr_q;
    assign aw_len_o   = aw_len_q;

    // Busy until the last queued burst has left the AW port
    assign busy_o = ~q_empty | aw_valid_q;

    // Credits stay within the queue plus the one AW held at the splitter
    assert property (@(posedge clk_i) disable iff (rst_i)
        credit_q <= credit_t'(`DMA_AW_QUEUE_DEPTH + 1));

    // A stalled AW keeps valid and payload until the handshake
    assert property (@(posedge clk_i) disable iff (rst_i)
        (aw_valid_o & ~aw_ready_i) |=>
            (aw_valid_o & $stable(aw_addr_o) & $stable(aw_len_o)));

endmodule

//--- logic/dma_ctrl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control-side types of the DMA backend
// Transfer lengths, credit counts, splitter states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dma_params.svh"

package dma_ctrl_pkg;

    // Transfer length in beats, not minus one
    typedef logic [`DMA_XFER_LEN_WIDTH-1:0] xfer_len_t;

    // Credit count, one step of headroom above the queue depth
    // for the AW still waiting at the splitter
    typedef logic [$clog2(`DMA_AW_QUEUE_DEPTH + 2)-1:0] credit_t;

    // Burst splitter FSM
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_ACCEPT
    } split_state_e;

endpackage

//--- logic/dma_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build-time sizes of the DMA address backend
// Included by the packages and by every RTL module
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// AXI address side
`define DMA_ADDR_WIDTH      32
// Burst length field, beats minus one as in AXI
`define DMA_LEN_WIDTH       8
`define DMA_XFER_LEN_WIDTH  16
`define DMA_MAX_BURST_BEATS 16
`define DMA_BYTES_PER_BEAT  4

// Queue depths, the AW queue depth also bounds the credits
`define DMA_AW_QUEUE_DEPTH  4
`define DMA_TRACK_DEPTH     4

`endif

//--- logic/dma_read_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Follows read bursts on the R channel, flags the
// first beat and the decouple bit of each burst
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dma_params.svh"

module dma_read_tracker (
    input  logic clk_i,
    input  logic rst_i,
    input  logic ar_issue_i,
    input  logic ar_issue_decouple_i,
    input  logic r_valid_i,
    input  logic r_ready_i,
    input  logic r_last_i,
    output logic r_first_o,
    output logic r_decouple_o
);

    localparam int PTR_W = $clog2(`DMA_TRACK_DEPTH);
    localparam int CNT_W = $clog2(`DMA_TRACK_DEPTH + 1);

    // Decouple flag per outstanding read burst
    logic [`DMA_TRACK_DEPTH-1:0] flags_q;
    logic [PTR_W-1:0]            wptr_q;
    logic [PTR_W-1:0]            rptr_q;
    logic [CNT_W-1:0]            cnt_q;
    logic                        in_burst_q;
    logic                        r_fire;
    logic                        pop;

    assign r_fire = r_valid_i & r_ready_i;
    assign pop    = r_fire & r_last_i;

    // First handshaked beat, also single-beat bursts
    assign r_first_o    = r_fire & ~in_burst_q;
    assign r_decouple_o = flags_q[rptr_q];

    always_ff @(posedge clk_i) begin
        if (ar_issue_i) begin
            flags_q[wptr_q] <= ar_issue_decouple_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wptr_q     <= '0;
            rptr_q     <= '0;
            cnt_q      <= '0;
            in_burst_q <= 1'b0;
        end else begin
            if (ar_issue_i) begin
                wptr_q <= (wptr_q == PTR_W'(`DMA_TRACK_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= (rptr_q == PTR_W'(`DMA_TRACK_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
            end
            if (ar_issue_i & ~pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop & ~ar_issue_i) begin
                cnt_q <= cnt_q - 1'b1;
            end
            // Inside a burst until its last beat
            if (r_fire) begin
                in_burst_q <= ~r_last_i;
            end
        end
    end

    // R data only for reads the splitter actually issued
    assert property (@(posedge clk_i) disable iff (rst_i)
        r_fire |-> (cnt_q != '0));

    // More outstanding reads than tracker slots
    assert property (@(posedge clk_i) disable iff (rst_i)
        (cnt_q == CNT_W'(`DMA_TRACK_DEPTH) & ar_issue_i) |-> pop);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the DMA backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_dma_backend \
    -o tb_dma_backend > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_dma_backend > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- sim.f
+incdir+logic
logic/dma_axi_pkg.sv
logic/dma_ctrl_pkg.sv
logic/dma_aw_queue.sv
logic/dma_read_tracker.sv
logic/dma_burst_splitter.sv
logic/dma_channel_coupler.sv
logic/dma_backend_top.sv
test/tb_dma_backend.sv

//--- test/tb_dma_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the DMA address backend
// Models the AR/R slave and checks AR and AW bursts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "dma_params.svh"

module tb_dma_backend
    import dma_axi_pkg::*;
    import dma_ctrl_pkg::*;
();

    // Roughly 1200 cycles of tests, limit with margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int RAND_XFERS     = 12;

    typedef struct packed {
        addr_t  addr;
        axlen_t len;
        logic   dec;
    } burst_t;

    logic      clk            = 1'b0;
    logic      rst_i          = 1'b1;
    logic      req_valid_i    = 1'b0;
    logic      req_ready_o;
    addr_t     req_src_addr_i = '0;
    addr_t     req_dst_addr_i = '0;
    xfer_len_t req_len_i      = '0;
    logic      req_decouple_i = 1'b0;
    logic      ar_valid_o;
    logic      ar_ready_i     = 1'b0;
    addr_t     ar_addr_o;
    axlen_t    ar_len_o;
    logic      r_valid_i      = 1'b0;
    logic      r_ready_i      = 1'b0;
    logic      r_last_i       = 1'b0;
    logic      aw_valid_o;
    logic      aw_ready_i     = 1'b0;
    addr_t     aw_addr_o;
    axlen_t    aw_len_o;
    logic      busy_o;

    // Expected bursts in issue order
    burst_t exp_ar[$];
    burst_t exp_aw[$];
    // Accepted ARs waiting for their R burst
    burst_t r_pend[$];
    // Decouple flag per AR still open on R
    logic   r_dec_q[$];

    int   outstanding    = 0;
    int   coupled_firsts = 0;
    int   coupled_aws    = 0;
    int   aw_count       = 0;
    int   mismatch_cnt   = 0;
    int   error_cnt      = 0;
    int   cycle_cnt      = 0;
    logic r_in_burst     = 1'b0;
    logic aw_seen        = 1'b0;

    // Ready control for the AR and AW slaves
    logic ar_ready_set = 1'b1;
    logic aw_ready_set = 1'b1;
    logic rand_ready   = 1'b0;

    always #2 clk = ~clk;

    dma_backend_top dma_backend_top_inst (
        .clk_i         (clk),
        .rst_i         (rst_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_src_addr_i(req_src_addr_i),
        .req_dst_addr_i(req_dst_addr_i),
        .req_len_i     (req_len_i),
        .req_decouple_i(req_decouple_i),
        .ar_valid_o    (ar_valid_o),
        .ar_ready_i    (ar_ready_i),
        .ar_addr_o     (ar_addr_o),
        .ar_len_o      (ar_len_o),
        .r_valid_i     (r_valid_i),
        .r_ready_i     (r_ready_i),
        .r_last_i      (r_last_i),
        .aw_valid_o    (aw_valid_o),
        .aw_ready_i    (aw_ready_i),
        .aw_addr_o     (aw_addr_o),
        .aw_len_o      (aw_len_o),
        .busy_o        (busy_o)
    );

    task automatic report_error(input string msg);
        error_cnt++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input axlen_t exp, input axlen_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // Splitting rule, bursts of at most the limit, address step per beat
    function automatic int expect_bursts(input addr_t src, input addr_t dst,
                                         input xfer_len_t len, input logic dec);
        int     left;
        int     n;
        int     count;
        burst_t b;
        left  = int'(len);
        count = 0;
        while (left > 0) begin
            n = (left > `DMA_MAX_BURST_BEATS) ? `DMA_MAX_BURST_BEATS : left;
            b.len  = axlen_t'(n - 1);
            b.dec  = dec;
            b.addr = src;
            exp_ar.push_back(b);
            b.addr = dst;
            exp_aw.push_back(b);
            src   = src + addr_t'(n * `DMA_BYTES_PER_BEAT);
            dst   = dst + addr_t'(n * `DMA_BYTES_PER_BEAT);
            left  = left - n;
            count = count + 1;
        end
        return count;
    endfunction

    // Offer one transfer and hold it until accepted
    task automatic send_request(input addr_t src, input addr_t dst, input xfer_len_t len,
                                input logic dec, output int nbursts);
        @(negedge clk);
        nbursts = expect_bursts(src, dst, len, dec);
        @(posedge clk);
        req_valid_i    <= 1'b1;
        req_src_addr_i <= src;
        req_dst_addr_i <= dst;
        req_len_i      <= len;
        req_decouple_i <= dec;
        do begin
            @(posedge clk);
        end while (!req_ready_o);
        req_valid_i <= 1'b0;
    endtask

    // R slave, one burst per accepted AR, in AR order
    task automatic return_r_bursts(input int count, input logic gaps);
        burst_t b;
        int     i;
        int     k;
        int     g;
        for (k = 0; k < count; k++) begin
            do begin
                @(negedge clk);
            end while (r_pend.size() == 0);
            b = r_pend.pop_front();
            @(posedge clk);
            for (i = 0; i <= int'(b.len); i++) begin
                g = gaps ? int'($urandom_range(0, 2)) : 0;
                if (g != 0) begin
                    r_valid_i <= 1'b0;
                    r_ready_i <= 1'b0;
                    repeat (g) @(posedge clk);
                end
                r_valid_i <= 1'b1;
                r_ready_i <= 1'b1;
                r_last_i  <= (i == int'(b.len));
                @(posedge clk);
            end
            r_valid_i <= 1'b0;
            r_ready_i <= 1'b0;
            r_last_i  <= 1'b0;
        end
    endtask

    task automatic wait_aw_count(input int target);
        do begin
            @(negedge clk);
        end while (aw_count < target);
    endtask

    task automatic set_ready(input logic ar, input logic aw);
        @(negedge clk);
        ar_ready_set = ar;
        aw_ready_set = aw;
    endtask

    task automatic after_reset_values();
        @(negedge clk);
        check_bit("req_ready_o", 1'b1, req_ready_o);
        check_bit("ar_valid_o", 1'b0, ar_valid_o);
        check_bit("aw_valid_o", 1'b0, aw_valid_o);
        check_bit("busy_o", 1'b0, busy_o);
    endtask

    task automatic coupled_single_burst();
        int base;
        int n;
        base = aw_count;
        send_request(32'h0000_1000, 32'h0000_8000, 16'd8, 1'b0, n);
        // No R yet, so AW must stay back while the queued AW keeps busy high
        repeat (20) begin
            @(negedge clk);
            check_bit("aw_valid_o", 1'b0, aw_valid_o);
            check_bit("busy_o", 1'b1, busy_o);
        end
        if (exp_ar.size() != 0) begin
            report_error("AR of the 8-beat transfer was not issued");
        end
        return_r_bursts(1, 1'b0);
        wait_aw_count(base + 1);
        check_bit("busy_o", 1'b0, busy_o);
    endtask

    task automatic decoupled_transfer();
        int base;
        int n;
        base = aw_count;
        send_request(32'h0000_2000, 32'h0000_9000, 16'd12, 1'b1, n);
        wait_aw_count(base + 1);
        // Retire the read so the tracker is empty again
        return_r_bursts(1, 1'b0);
    endtask

    task automatic split_long_transfer();
        int base;
        int n;
        int k;
        base = aw_count;
        send_request(32'h0000_4000, 32'h0000_A000, 16'd40, 1'b0, n);
        repeat (20) begin
            @(negedge clk);
            check_bit("aw_valid_o", 1'b0, aw_valid_o);
        end
        // One AW per R burst started
        for (k = 0; k < n; k++) begin
            return_r_bursts(1, 1'b0);
            wait_aw_count(base + k + 1);
        end
    endtask

    task automatic aw_backpressure();
        int base;
        int n;
        base = aw_count;
        set_ready(1'b1, 1'b0);
        send_request(32'h0001_0000, 32'h0002_0000, 16'd64, 1'b0, n);
        return_r_bursts(3, 1'b0);
        repeat (4) @(negedge clk);
        // First AW parked at the port, two credits banked
        check_bit("aw_valid_o", 1'b1, aw_valid_o);
        if (aw_count != base) begin
            report_error("AW handshake while aw_ready_i was low");
        end
        set_ready(1'b1, 1'b1);
        wait_aw_count(base + 3);
        repeat (20) begin
            @(negedge clk);
            check_bit("aw_valid_o", 1'b0, aw_valid_o);
        end
        if (aw_count != base + 3) begin
            report_error("fourth AW left without a matching R burst");
        end
        return_r_bursts(1, 1'b0);
        wait_aw_count(base + 4);
    endtask

    task automatic random_mix();
        int        i;
        int        n;
        int        total;
        int        base;
        addr_t     src;
        addr_t     dst;
        xfer_len_t len;
        logic      dec;
        base  = aw_count;
        total = 0;
        @(negedge clk);
        rand_ready = 1'b1;
        for (i = 0; i < RAND_XFERS; i++) begin
            len = xfer_len_t'($urandom_range(0, 50));
            dec = ($urandom_range(0, 1) == 1);
            src = addr_t'($urandom) & ~addr_t'(3);
            dst = addr_t'($urandom) & ~addr_t'(3);
            send_request(src, dst, len, dec, n);
            return_r_bursts(n, 1'b1);
            total = total + n;
        end
        @(negedge clk);
        rand_ready = 1'b0;
        wait_aw_count(base + total);
        do begin
            @(negedge clk);
        end while (busy_o);
    endtask

    // Handshake monitor, scoreboard and ready generation
    always @(posedge clk) begin
        burst_t b;
        if (!rst_i) begin
            // R first, its credit precedes any AW seen later
            if (r_valid_i && r_ready_i) begin
                if (r_dec_q.size() == 0) begin
                    report_error("R beat with no read burst outstanding");
                end else begin
                    if (!r_in_burst && !r_dec_q[0]) begin
                        coupled_firsts++;
                    end
                    r_in_burst = !r_last_i;
                    if (r_last_i) begin
                        void'(r_dec_q.pop_front());
                        outstanding--;
                    end
                end
            end
            if (ar_valid_o && ar_ready_i) begin
                if (exp_ar.size() == 0) begin
                    report_error("AR burst that no transfer asked for");
                end else begin
                    b = exp_ar.pop_front();
                    check_addr("ar_addr_o", b.addr, ar_addr_o);
                    check_len("ar_len_o", b.len, ar_len_o);
                    r_pend.push_back(b);
                    r_dec_q.push_back(b.dec);
                    outstanding++;
                end
            end
            // New AW on the port, a coupled one needs an unspent R first beat
            if (aw_valid_o && !aw_seen) begin
                aw_seen = 1'b1;
                if (exp_aw.size() == 0) begin
                    report_error("AW valid with no burst expected");
                end else if (!exp_aw[0].dec) begin
                    if (coupled_aws >= coupled_firsts) begin
                        report_error("coupled AW released before its R first beat");
                    end
                    coupled_aws++;
                end
            end
            if (aw_valid_o && aw_ready_i) begin
                aw_seen = 1'b0;
                if (exp_aw.size() != 0) begin
                    b = exp_aw.pop_front();
                    check_addr("aw_addr_o", b.addr, aw_addr_o);
                    check_len("aw_len_o", b.len, aw_len_o);
                end
                aw_count++;
            end
        end
        // Slave keeps at most the tracker depth of reads open
        if (rand_ready) begin
            ar_ready_i <= (outstanding < `DMA_TRACK_DEPTH) && ($urandom_range(0, 3) != 0);
            aw_ready_i <= ($urandom_range(0, 3) != 0);
        end else begin
            ar_ready_i <= (outstanding < `DMA_TRACK_DEPTH) && ar_ready_set;
            aw_ready_i <= aw_ready_set;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(46));
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        after_reset_values();
        coupled_single_burst();
        decoupled_transfer();
        split_long_transfer();
        aw_backpressure();
        random_mix();
        if (exp_ar.size() != 0 || exp_aw.size() != 0 || r_pend.size() != 0) begin
            report_error("expected bursts still pending at the end");
        end
        $display("Errors: %0d mismatches, %0d other", mismatch_cnt, error_cnt);
        if (mismatch_cnt == 0 && error_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
